// File: list.f
logic/shell_pkg.sv
logic/sleep_ctrl.sv
logic/regfile_ff.sv
logic/regfile_bank.sv
logic/scramble_key_ctrl.sv
logic/rv_core_shell.sv
test/tb_rv_core_shell.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core shell testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_rv_core_shell \
  -Mdir obj_dir \
  -f list.f

./obj_dir/Vtb_rv_core_shell | tee sim.log

if grep -qx "All tests passed" sim.log; then
  exit 0
else
  exit 1
fi

// File: test/tb_rv_core_shell.sv
/*
 * Testbench for the core shell: clock, reset, core model stimulus,
 * register file reference model, assertions and watchdog
 */
`timescale 1ns/1ns

module tb_rv_core_shell;

  localparam int unsigned ClkPeriod   = 20;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned NumWrites   = 40;
  // Reset, random writes, x0/f0, sleep walk, key exchange
  localparam int unsigned TestCycles    = ResetCycles + 1 + NumWrites * 2 + 4 + 26 + 10;
  localparam int unsigned TimeoutCycles = TestCycles + 100;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              test_en_i;
  logic                              core_busy_i;
  logic                              debug_req_i;
  logic                              irq_pending_i;
  logic                              irq_nm_i;
  logic                              core_sleep_o;
  logic [shell_pkg::RegAddrW-1:0]    rf_raddr_a_i;
  logic [shell_pkg::RegAddrW-1:0]    rf_raddr_b_i;
  logic [shell_pkg::RegAddrW-1:0]    rf_waddr_i;
  logic [shell_pkg::RegDataW-1:0]    rf_wdata_i;
  logic                              rf_we_i;
  logic                              rf_fp_wdata_sel_i;
  logic                              rf_fp_rdata_a_sel_i;
  logic                              rf_fp_rdata_b_sel_i;
  logic [shell_pkg::RegDataW-1:0]    rf_rdata_a_o;
  logic [shell_pkg::RegDataW-1:0]    rf_rdata_b_o;
  logic                              icache_inval_i;
  logic                              scramble_key_valid_i;
  logic [shell_pkg::ScrKeyW-1:0]     scramble_key_i;
  logic [shell_pkg::ScrNonceW-1:0]   scramble_nonce_i;
  logic                              scramble_req_o;
  logic                              scr_key_valid_o;
  logic [shell_pkg::ScrKeyW-1:0]     scr_key_o;
  logic [shell_pkg::ScrNonceW-1:0]   scr_nonce_o;

  logic [shell_pkg::RegDataW-1:0] int_model [shell_pkg::NumRegs];
  logic [shell_pkg::RegDataW-1:0] fp_model [shell_pkg::NumRegs];
  logic [31:0]                    rng;
  logic                           busy_seen;
  int unsigned                    mismatch_errors;
  int unsigned                    assert_errors;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  rv_core_shell u_rv_core_shell (
    .clk_i, .rst_ni, .test_en_i,
    .core_busy_i, .debug_req_i, .irq_pending_i, .irq_nm_i, .core_sleep_o,
    .rf_raddr_a_i, .rf_raddr_b_i, .rf_waddr_i, .rf_wdata_i, .rf_we_i,
    .rf_fp_wdata_sel_i, .rf_fp_rdata_a_sel_i, .rf_fp_rdata_b_sel_i,
    .rf_rdata_a_o, .rf_rdata_b_o,
    .icache_inval_i, .scramble_key_valid_i, .scramble_key_i, .scramble_nonce_i,
    .scramble_req_o, .scr_key_valid_o, .scr_key_o, .scr_nonce_o
  );

  // Busy as the core presented it at the last edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_seen <= 1'b0;
    end else begin
      busy_seen <= core_busy_i;
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_sleep_o == !(busy_seen | debug_req_i | irq_pending_i | irq_nm_i))
    else begin
      assert_errors = assert_errors + 1;
      $display("Sleep output disagrees with busy and wake inputs at %0t", $time);
    end

  // A pending request always means the key is not valid yet
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      scramble_req_o |-> !scr_key_valid_o)
    else begin
      assert_errors = assert_errors + 1;
      $display("Key reported valid while a key request is pending at %0t", $time);
    end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Low LCG bits repeat quickly so the high half is folded in
  task automatic rand_word(output logic [31:0] r);
    rng = lcg_step(rng);
    r   = rng ^ (rng >> 16);
  endtask

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (exp == act)
      else begin
        mismatch_errors = mismatch_errors + 1;
        $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
      end
  endtask

  function automatic logic [31:0] model_read(input logic fp, input logic [4:0] addr);
    return fp ? fp_model[addr] : int_model[addr];
  endfunction

  // x0 ignores writes, f0 does not
  task automatic model_write(input logic fp, input logic [4:0] addr, input logic [31:0] data);
    if (fp) begin
      fp_model[addr] = data;
    end else if (addr != 5'd0) begin
      int_model[addr] = data;
    end
  endtask

  task automatic write_reg(input logic fp, input logic [4:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    rf_we_i           = 1'b1;
    rf_fp_wdata_sel_i = fp;
    rf_waddr_i        = addr;
    rf_wdata_i        = data;
    @(negedge clk_i);
    rf_we_i = 1'b0;
  endtask

  // Called on a falling edge, checks both ports mid phase
  task automatic read_check(input string name, input logic fp_a, input logic [4:0] addr_a,
                            input logic fp_b, input logic [4:0] addr_b);
    rf_raddr_a_i        = addr_a;
    rf_raddr_b_i        = addr_b;
    rf_fp_rdata_a_sel_i = fp_a;
    rf_fp_rdata_b_sel_i = fp_b;
    #(ClkPeriod / 4);
    check_value({name, " port a"}, 128'(model_read(fp_a, addr_a)), 128'(rf_rdata_a_o));
    check_value({name, " port b"}, 128'(model_read(fp_b, addr_b)), 128'(rf_rdata_b_o));
  endtask

  initial begin
    logic [31:0]  r;
    logic [31:0]  d;
    logic [127:0] new_key;
    logic [63:0]  new_nonce;

    clk_i = 1'b0;
    rst_ni = 1'b0;
    test_en_i = 1'b0;
    core_busy_i = 1'b0;
    debug_req_i = 1'b0;
    irq_pending_i = 1'b0;
    irq_nm_i = 1'b0;
    rf_raddr_a_i = '0;
    rf_raddr_b_i = '0;
    rf_waddr_i = '0;
    rf_wdata_i = '0;
    rf_we_i = 1'b0;
    rf_fp_wdata_sel_i = 1'b0;
    rf_fp_rdata_a_sel_i = 1'b0;
    rf_fp_rdata_b_sel_i = 1'b0;
    icache_inval_i = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i = '0;
    scramble_nonce_i = '0;
    rng = 32'd58;
    mismatch_errors = 0;
    assert_errors = 0;
    for (int i = 0; i < shell_pkg::NumRegs; i++) begin
      int_model[i] = '0;
      fp_model[i]  = '0;
    end

    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset values
    #(ClkPeriod / 4);
    check_value("reset req", 128'(1'b0), 128'(scramble_req_o));
    check_value("reset key valid", 128'(1'b1), 128'(scr_key_valid_o));
    check_value("reset key", 128'(shell_pkg::ScrKeyDefault), 128'(scr_key_o));
    check_value("reset nonce", 128'(shell_pkg::ScrNonceDefault), 128'(scr_nonce_o));
    check_value("reset sleep", 128'(1'b1), 128'(core_sleep_o));

    ////////////////////////////// Random writes and reads
    @(negedge clk_i);
    core_busy_i = 1'b1;
    for (int n = 0; n < NumWrites; n++) begin
      rand_word(r);
      rand_word(d);
      write_reg(r[0], r[5:1], d);
      model_write(r[0], r[5:1], d);
      read_check("random rw", r[6], r[5:1], r[7], r[12:8]);
    end

    // Register 0 of each file
    write_reg(1'b0, 5'd0, 32'hdead_beef);
    model_write(1'b0, 5'd0, 32'hdead_beef);
    read_check("int x0", 1'b0, 5'd0, 1'b0, 5'd0);
    write_reg(1'b1, 5'd0, 32'h1234_5678);
    model_write(1'b1, 5'd0, 32'h1234_5678);
    read_check("fp f0", 1'b1, 5'd0, 1'b1, 5'd0);
    check_value("fp f0 value", 128'(32'h1234_5678), 128'(rf_rdata_a_o));

    ////////////////////////////// Sleep and wake
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = 4'(i);
    end
    @(negedge clk_i);
    {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = 4'b0000;
    @(negedge clk_i);
    #(ClkPeriod / 4);
    check_value("asleep", 128'(1'b1), 128'(core_sleep_o));
    write_reg(1'b0, 5'd5, ~int_model[5]);
    read_check("write while asleep", 1'b0, 5'd5, 1'b0, 5'd5);
    @(negedge clk_i);
    irq_nm_i = 1'b1;
    rand_word(d);
    write_reg(1'b1, 5'd9, d);
    model_write(1'b1, 5'd9, d);
    read_check("write on nmi wake", 1'b1, 5'd9, 1'b1, 5'd9);
    @(negedge clk_i);
    irq_nm_i = 1'b0;

    ////////////////////////////// Scramble key exchange
    rand_word(r);
    rand_word(d);
    new_key = {r, d, ~r, ~d};
    new_nonce = {d, r};
    // Key bus carries the new key early, without valid
    scramble_key_i = new_key;
    scramble_nonce_i = new_nonce;
    icache_inval_i = 1'b1;
    @(negedge clk_i);
    icache_inval_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      #(ClkPeriod / 4);
      check_value("key request held", 128'(1'b1), 128'(scramble_req_o));
      check_value("key invalid held", 128'(1'b0), 128'(scr_key_valid_o));
      check_value("old key held", 128'(shell_pkg::ScrKeyDefault), 128'(scr_key_o));
      check_value("old nonce held", 128'(shell_pkg::ScrNonceDefault), 128'(scr_nonce_o));
      @(negedge clk_i);
    end
    scramble_key_valid_i = 1'b1;
    @(negedge clk_i);
    scramble_key_valid_i = 1'b0;
    #(ClkPeriod / 4);
    check_value("key request done", 128'(1'b0), 128'(scramble_req_o));
    check_value("key valid again", 128'(1'b1), 128'(scr_key_valid_o));
    check_value("new key", new_key, 128'(scr_key_o));
    check_value("new nonce", 128'(new_nonce), 128'(scr_nonce_o));

    @(negedge clk_i);
    $display("Errors: %0d mismatches, %0d assertion failures", mismatch_errors,
             assert_errors);
    if (mismatch_errors == 0 && assert_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: logic/rv_core_shell.sv
/*
 * Glue around a RISC-V hart: sleep control and clock gate,
 * integer and FP register bank, scramble key control
 */
`timescale 1ns/1ns

module rv_core_shell (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           test_en_i,

  // Sleep and wake
  input  logic                           core_busy_i,
  input  logic                           debug_req_i,
  input  logic                           irq_pending_i,
  input  logic                           irq_nm_i,
  output logic                           core_sleep_o,

  // Register bank
  input  logic [shell_pkg::RegAddrW-1:0]  rf_raddr_a_i,
  input  logic [shell_pkg::RegAddrW-1:0]  rf_raddr_b_i,
  input  logic [shell_pkg::RegAddrW-1:0]  rf_waddr_i,
  input  logic [shell_pkg::RegDataW-1:0]  rf_wdata_i,
  input  logic                           rf_we_i,
  input  logic                           rf_fp_wdata_sel_i,
  input  logic                           rf_fp_rdata_a_sel_i,
  input  logic                           rf_fp_rdata_b_sel_i,
  output logic [shell_pkg::RegDataW-1:0]  rf_rdata_a_o,
  output logic [shell_pkg::RegDataW-1:0]  rf_rdata_b_o,

  // Scrambling
  input  logic                           icache_inval_i,
  input  logic                           scramble_key_valid_i,
  input  logic [shell_pkg::ScrKeyW-1:0]   scramble_key_i,
  input  logic [shell_pkg::ScrNonceW-1:0] scramble_nonce_i,
  output logic                           scramble_req_o,
  output logic                           scr_key_valid_o,
  output logic [shell_pkg::ScrKeyW-1:0]   scr_key_o,
  output logic [shell_pkg::ScrNonceW-1:0] scr_nonce_o
);

  import shell_pkg::*;

  logic clk_gated;

  //////////////////////////////
  // Sleep control
  //////////////////////////////

  sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .core_sleep_o (core_sleep_o),
    .clk_gated_o  (clk_gated)
  );

  //////////////////////////////
  // Register bank
  //////////////////////////////

  // Writes stop while the core sleeps
  regfile_bank u_regfile_bank (
    .clk_i           (clk_gated),
    .rst_ni          (rst_ni),
    .raddr_a_i       (rf_raddr_a_i),
    .raddr_b_i       (rf_raddr_b_i),
    .waddr_i         (rf_waddr_i),
    .wdata_i         (rf_wdata_i),
    .we_i            (rf_we_i),
    .fp_wdata_sel_i  (rf_fp_wdata_sel_i),
    .fp_rdata_a_sel_i(rf_fp_rdata_a_sel_i),
    .fp_rdata_b_sel_i(rf_fp_rdata_b_sel_i),
    .rdata_a_o       (rf_rdata_a_o),
    .rdata_b_o       (rf_rdata_b_o)
  );

  //////////////////////////////
  // Scramble key control
  //////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .icache_inval_i(icache_inval_i),
    .key_valid_i   (scramble_key_valid_i),
    .key_i         (scramble_key_i),
    .nonce_i       (scramble_nonce_i),
    .req_o         (scramble_req_o),
    .key_valid_o   (scr_key_valid_o),
    .key_o         (scr_key_o),
    .nonce_o       (scr_nonce_o)
  );

endmodule

// File: logic/scramble_key_ctrl.sv
/*
 * Instruction cache scramble key control: key request,
 * key valid flag, key and nonce storage
 */
`timescale 1ns/1ns

module scramble_key_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           icache_inval_i,
  input  logic                           key_valid_i,
  input  logic [shell_pkg::ScrKeyW-1:0]   key_i,
  input  logic [shell_pkg::ScrNonceW-1:0] nonce_i,
  output logic                           req_o,
  output logic                           key_valid_o,
  output logic [shell_pkg::ScrKeyW-1:0]   key_o,
  output logic [shell_pkg::ScrNonceW-1:0] nonce_o
);

  import shell_pkg::*;

  logic                 req_d, req_q;
  logic                 key_valid_d, key_valid_q;
  logic [ScrKeyW-1:0]   key_q;
  logic [ScrNonceW-1:0] nonce_q;

  // Request starts on invalidation and holds until a key arrives
  assign req_d = req_q ? ~key_valid_i : icache_inval_i;

  // Valid drops on invalidation, then follows OTP while requesting
  assign key_valid_d = req_q          ? key_valid_i :
                       icache_inval_i ? 1'b0        :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  //////////////////////////////
  // Key and nonce
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= ScrKeyDefault;
      nonce_q <= ScrNonceDefault;
    end else if (key_valid_i) begin
      key_q   <= key_i;
      nonce_q <= nonce_i;
    end
  end

  assign req_o       = req_q;
  assign key_valid_o = key_valid_q;
  assign key_o       = key_q;
  assign nonce_o     = nonce_q;

endmodule

// File: logic/regfile_bank.sv
/*
 * Integer and floating-point register files sharing one set of
 * addresses, with write steering and per-port read selection
 */
`timescale 1ns/1ns

module regfile_bank (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [shell_pkg::RegAddrW-1:0] raddr_a_i,
  input  logic [shell_pkg::RegAddrW-1:0] raddr_b_i,
  input  logic [shell_pkg::RegAddrW-1:0] waddr_i,
  input  logic [shell_pkg::RegDataW-1:0] wdata_i,
  input  logic                          we_i,
  input  logic                          fp_wdata_sel_i,
  input  logic                          fp_rdata_a_sel_i,
  input  logic                          fp_rdata_b_sel_i,
  output logic [shell_pkg::RegDataW-1:0] rdata_a_o,
  output logic [shell_pkg::RegDataW-1:0] rdata_b_o
);

  import shell_pkg::*;

  logic                int_we;
  logic                fp_we;
  logic [RegDataW-1:0] int_rdata_a, int_rdata_b;
  logic [RegDataW-1:0] fp_rdata_a, fp_rdata_b;

  // Only one file sees the write
  assign int_we = we_i & ~fp_wdata_sel_i;
  assign fp_we  = we_i & fp_wdata_sel_i;

  regfile_ff #(
    .ZeroReg0(1'b1)
  ) u_int_rf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(raddr_a_i),
    .raddr_b_i(raddr_b_i),
    .rdata_a_o(int_rdata_a),
    .rdata_b_o(int_rdata_b),
    .waddr_i  (waddr_i),
    .wdata_i  (wdata_i),
    .we_i     (int_we)
  );

  // f0 is an ordinary register
  regfile_ff #(
    .ZeroReg0(1'b0)
  ) u_fp_rf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(raddr_a_i),
    .raddr_b_i(raddr_b_i),
    .rdata_a_o(fp_rdata_a),
    .rdata_b_o(fp_rdata_b),
    .waddr_i  (waddr_i),
    .wdata_i  (wdata_i),
    .we_i     (fp_we)
  );

  assign rdata_a_o = fp_rdata_a_sel_i ? fp_rdata_a : int_rdata_a;
  assign rdata_b_o = fp_rdata_b_sel_i ? fp_rdata_b : int_rdata_b;

endmodule

// File: logic/regfile_ff.sv
/*
 * Flip-flop register file, two read ports and one write port,
 * with optional hard-wired zero at register 0
 */
`timescale 1ns/1ns

module regfile_ff #(
  parameter bit ZeroReg0 = 1'b1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [shell_pkg::RegAddrW-1:0] raddr_a_i,
  input  logic [shell_pkg::RegAddrW-1:0] raddr_b_i,
  output logic [shell_pkg::RegDataW-1:0] rdata_a_o,
  output logic [shell_pkg::RegDataW-1:0] rdata_b_o,
  input  logic [shell_pkg::RegAddrW-1:0] waddr_i,
  input  logic [shell_pkg::RegDataW-1:0] wdata_i,
  input  logic                          we_i
);

  import shell_pkg::*;

  logic [RegDataW-1:0] mem [NumRegs];
  logic [NumRegs-1:0]  we_dec;

  // Write address decode
  always_comb begin
    for (int unsigned i = 0; i < NumRegs; i++) begin
      we_dec[i] = we_i & (waddr_i == RegAddrW'(i));
    end
  end

  for (genvar i = 0; i < NumRegs; i++) begin : gen_regs
    if (ZeroReg0 && (i == 0)) begin : gen_zero
      assign mem[i] = '0;
    end else begin : gen_ff
      logic [RegDataW-1:0] reg_q;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          reg_q <= '0;
        end else if (we_dec[i]) begin
          reg_q <= wdata_i;
        end
      end

      assign mem[i] = reg_q;
    end
  end

  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];

endmodule

// File: logic/sleep_ctrl.sv
/*
 * Core sleep control: registered busy flag, wake sources,
 * sleep output and latch based clock gate
 */
`timescale 1ns/1ns

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic core_sleep_o,
  output logic clk_gated_o
);

  logic core_busy_q;
  logic clock_en;
  logic en_latched;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the clock running
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  //////////////////////////////
  // Clock gate
  //////////////////////////////

  // Enable only changes while clk_i is low, so no glitch on the AND
  always_latch begin
    if (!clk_i) begin
      en_latched = clock_en | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & en_latched;

endmodule

// File: logic/shell_pkg.sv
/*
 * Shared widths for the core shell: register file geometry,
 * scramble key and nonce sizes, and their reset values
 */
package shell_pkg;

  //////////////////////////////
  // Register files
  //////////////////////////////

  localparam int unsigned RegAddrW = 5;
  localparam int unsigned NumRegs  = 32;
  localparam int unsigned RegDataW = 32;

  //////////////////////////////
  // Instruction cache scrambling
  //////////////////////////////

  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  // Used until the first key arrives from OTP
  localparam logic [ScrKeyW-1:0] ScrKeyDefault =
    128'h3b7a_91c4_e205_6d8f_a1c3_5e97_0b24_d6f8;
  localparam logic [ScrNonceW-1:0] ScrNonceDefault =
    64'hc48e_2a17_95d3_6f0b;

endpackage
